/* Makefile */
# Verilator build and run for the data cache testbench

VERILATOR ?= verilator
TOP       ?= tb_dcache
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= TB PASSED

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the output is searched for the pass line, the shell status follows grep
run: compile
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* common/dcache_pkg.sv */
package dcache_pkg;

    localparam int ADDR_W = 32;
    localparam int LINE_W = 64;
    localparam int INDEX_W = 6;
    localparam int TAG_W = 23;
    localparam int NUM_LINES = 64;

    // one cache line, word 0 sits at the lower address
    typedef union packed {
        logic [LINE_W-1:0] raw;
        logic [1:0][31:0] word;
    } dcache_line_u;

    typedef enum logic [2:0] {
        st_idle,
        st_lookup,
        st_fill,
        st_bus_read,
        st_write_bus,
        st_update,
        st_span_next,
        st_deliver
    } ctrl_state_e;

endpackage

/* dcache/dcache_ctrl.sv */
`timescale 1ns/1ps

module dcache_ctrl (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            req_pending,
    input  logic                            is_write,
    input  logic                            span,
    input  logic                            wide_write,
    input  logic [dcache_pkg::ADDR_W-1:0]   lookup_addr,
    input  logic [dcache_pkg::LINE_W-1:0]   write_data,
    output logic                            next_line,
    output logic                            req_done,
    output logic [dcache_pkg::ADDR_W-1:0]   virt_addr,
    input  logic [dcache_pkg::ADDR_W-1:0]   phys_addr,
    input  logic                            tlb_hit,
    input  logic                            tlb_pcd,
    output logic                            page_fault,
    output logic [dcache_pkg::INDEX_W-1:0]  store_index,
    output logic                            store_we,
    output logic [dcache_pkg::LINE_W-1:0]   store_wline,
    output logic [dcache_pkg::TAG_W-1:0]    store_tag_w,
    input  logic [dcache_pkg::TAG_W-1:0]    store_tag,
    input  logic                            store_valid,
    input  logic [dcache_pkg::LINE_W-1:0]   store_line,
    output logic                            stage_load,
    output logic                            half_sel,
    output logic                            result_valid,
    input  logic                            result_taken,
    output logic [31:0]                     stage_word,
    output logic                            wb_cyc,
    output logic                            wb_stb,
    output logic                            wb_we,
    output logic [31:0]                     wb_adr,
    output logic [31:0]                     wb_dat_w,
    output logic [3:0]                      wb_sel,
    input  logic                            wb_ack,
    input  logic [31:0]                     wb_dat_r
);

    dcache_pkg::ctrl_state_e state;
    dcache_pkg::ctrl_state_e state_n;
    dcache_pkg::dcache_line_u rd_line;
    dcache_pkg::dcache_line_u fill_line;
    dcache_pkg::dcache_line_u line_q;
    dcache_pkg::dcache_line_u merge_line;

    logic        wcnt;
    logic        fcnt;
    logic        wr_hit;
    logic [31:0] accum;
    logic        cache_hit;
    logic        word_sel;
    logic        last_word;
    logic        word_done;
    logic        bus_issue;
    logic        bus_end;
    logic [31:0] bus_adr;
    logic [31:0] wr_word;

    assign virt_addr   = lookup_addr;
    assign store_index = lookup_addr[8:3];
    assign store_tag_w = phys_addr[dcache_pkg::ADDR_W-1:9];

    assign cache_hit = store_valid && (store_tag == store_tag_w) && !tlb_pcd;
    // word of the current line that serves request word wcnt
    assign word_sel  = lookup_addr[2] ^ wcnt;
    assign last_word = wcnt || (is_write && !wide_write);
    assign wr_word   = wcnt ? write_data[63:32] : write_data[31:0];
    assign bus_end   = wb_cyc && wb_ack;

    assign rd_line.raw       = store_line;
    assign fill_line.word[0] = accum;
    assign fill_line.word[1] = wb_dat_r;

    always_comb begin
        merge_line = line_q;
        merge_line.word[word_sel] = wr_word;
    end

    assign half_sel     = wcnt;
    assign result_valid = (state == dcache_pkg::st_deliver);

    always_comb begin
        state_n     = state;
        word_done   = 1'b0;
        store_we    = 1'b0;
        store_wline = fill_line.raw;
        stage_load  = 1'b0;
        stage_word  = rd_line.word[word_sel];
        page_fault  = 1'b0;
        req_done    = 1'b0;
        next_line   = 1'b0;
        bus_issue   = 1'b0;
        bus_adr     = {phys_addr[dcache_pkg::ADDR_W-1:3], word_sel, 2'b00};
        case (state)
            dcache_pkg::st_idle: begin
                if (req_pending) begin
                    state_n = dcache_pkg::st_lookup;
                end
            end
            dcache_pkg::st_lookup: begin
                if (!tlb_hit) begin
                    page_fault = 1'b1;
                    req_done   = 1'b1;
                    state_n    = dcache_pkg::st_idle;
                end else if (is_write) begin
                    state_n = dcache_pkg::st_write_bus;
                end else if (tlb_pcd) begin
                    state_n = dcache_pkg::st_bus_read;
                end else if (cache_hit) begin
                    stage_load = 1'b1;
                    word_done  = 1'b1;
                end else begin
                    state_n = dcache_pkg::st_fill;
                end
            end
            dcache_pkg::st_fill: begin
                bus_issue = !wb_cyc;
                bus_adr   = {phys_addr[dcache_pkg::ADDR_W-1:3], fcnt, 2'b00};
                // second word completes the line, then look it up again
                if (bus_end && fcnt) begin
                    store_we = 1'b1;
                    state_n  = dcache_pkg::st_lookup;
                end
            end
            dcache_pkg::st_bus_read: begin
                bus_issue  = !wb_cyc;
                stage_word = wb_dat_r;
                if (bus_end) begin
                    stage_load = 1'b1;
                    word_done  = 1'b1;
                end
            end
            dcache_pkg::st_write_bus: begin
                bus_issue = !wb_cyc;
                if (bus_end) begin
                    if (wr_hit) begin
                        state_n = dcache_pkg::st_update;
                    end else begin
                        word_done = 1'b1;
                    end
                end
            end
            dcache_pkg::st_update: begin
                store_we    = 1'b1;
                store_wline = merge_line.raw;
                word_done   = 1'b1;
            end
            dcache_pkg::st_span_next: begin
                state_n = dcache_pkg::st_lookup;
            end
            dcache_pkg::st_deliver: begin
                if (result_taken) begin
                    req_done = 1'b1;
                    state_n  = dcache_pkg::st_idle;
                end
            end
            default: begin
                state_n = dcache_pkg::st_idle;
            end
        endcase

        // common exit once a request word has been handled
        if (word_done) begin
            if (last_word) begin
                if (is_write) begin
                    req_done = 1'b1;
                    state_n  = dcache_pkg::st_idle;
                end else begin
                    state_n = dcache_pkg::st_deliver;
                end
            end else if (span) begin
                next_line = 1'b1;
                state_n   = dcache_pkg::st_span_next;
            end else begin
                state_n = dcache_pkg::st_lookup;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state  <= dcache_pkg::st_idle;
            wcnt   <= 1'b0;
            fcnt   <= 1'b0;
            wb_cyc <= 1'b0;
        end else begin
            state <= state_n;
            if (req_done) begin
                wcnt <= 1'b0;
            end else if (word_done && !last_word) begin
                wcnt <= 1'b1;
            end
            if (bus_end && state == dcache_pkg::st_fill) begin
                fcnt <= !fcnt;
            end
            if (bus_issue) begin
                wb_cyc <= 1'b1;
            end else if (bus_end) begin
                wb_cyc <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (bus_end && state == dcache_pkg::st_fill && !fcnt) begin
            accum <= wb_dat_r;
        end
        // hit status and old line kept for the write merge
        if (state == dcache_pkg::st_lookup) begin
            wr_hit     <= cache_hit;
            line_q.raw <= store_line;
        end
        if (bus_issue) begin
            wb_adr   <= bus_adr;
            wb_we    <= is_write;
            wb_dat_w <= wr_word;
        end
    end

    assign wb_stb = wb_cyc;
    assign wb_sel = 4'hf;

endmodule

/* dcache/dcache_read_align.sv */
`timescale 1ns/1ps

module dcache_read_align (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            stage_load,
    input  logic                            half_sel,
    input  logic [31:0]                     stage_word,
    input  logic                            result_valid,
    output logic                            result_taken,
    output logic                            rd_dp_valid,
    input  logic                            rd_dp_ready,
    output logic [dcache_pkg::LINE_W-1:0]   rd_dp_read_data
);

    dcache_pkg::dcache_line_u staging;

    // low half first, high half possibly from the next line
    always_ff @(posedge clk) begin
        if (stage_load) begin
            staging.word[half_sel] <= stage_word;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_dp_valid <= 1'b0;
        end else if (result_taken) begin
            rd_dp_valid <= 1'b0;
        end else if (result_valid) begin
            rd_dp_valid <= 1'b1;
        end
    end

    assign result_taken    = rd_dp_valid && rd_dp_ready;
    assign rd_dp_read_data = staging.raw;

endmodule

/* dcache/dcache_req_decode.sv */
`timescale 1ns/1ps

module dcache_req_decode (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            rd_req_valid,
    input  logic                            wr_req_valid,
    output logic                            rd_req_ready,
    output logic                            wr_req_ready,
    input  logic [dcache_pkg::ADDR_W-1:0]   rd_req_address,
    input  logic [dcache_pkg::ADDR_W-1:0]   wr_req_address,
    input  logic [dcache_pkg::LINE_W-1:0]   wr_req_data,
    input  logic                            wr_size,
    input  logic                            req_done,
    input  logic                            next_line,
    output logic [dcache_pkg::ADDR_W-1:0]   lookup_addr,
    output logic                            span,
    output logic                            is_write,
    output logic                            wide_write,
    output logic [dcache_pkg::LINE_W-1:0]   write_data,
    output logic                            req_pending
);

    logic                          wr_accept;
    logic                          rd_accept;
    logic [dcache_pkg::ADDR_W-1:0] req_addr;

    // writes win when both sides offer a request
    assign wr_req_ready = !req_pending;
    assign rd_req_ready = !req_pending && !wr_req_valid;

    assign wr_accept = wr_req_valid && wr_req_ready;
    assign rd_accept = rd_req_valid && rd_req_ready;
    assign req_addr  = wr_req_valid ? wr_req_address : rd_req_address;

    always_ff @(posedge clk) begin
        if (reset) begin
            req_pending <= 1'b0;
        end else if (wr_accept || rd_accept) begin
            req_pending <= 1'b1;
        end else if (req_done) begin
            req_pending <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_accept || rd_accept) begin
            lookup_addr <= {req_addr[dcache_pkg::ADDR_W-1:2], 2'b00};
            is_write    <= wr_accept;
            wide_write  <= wr_accept && wr_size;
            // second word lands in the next line
            span        <= req_addr[2] && (rd_accept || wr_size);
            write_data  <= wr_req_data;
        end else if (next_line) begin
            lookup_addr <= lookup_addr + 32'd8;
        end
    end

endmodule

/* dcache/dcache_store.sv */
`timescale 1ns/1ps

module dcache_store (
    input  logic                            clk,
    input  logic                            reset,
    input  logic [dcache_pkg::INDEX_W-1:0]  store_index,
    input  logic                            store_we,
    input  logic [dcache_pkg::LINE_W-1:0]   store_wline,
    input  logic [dcache_pkg::TAG_W-1:0]    store_tag_w,
    output logic [dcache_pkg::TAG_W-1:0]    store_tag,
    output logic                            store_valid,
    output logic [dcache_pkg::LINE_W-1:0]   store_line
);

    logic [dcache_pkg::TAG_W-1:0]     tag_mem  [dcache_pkg::NUM_LINES];
    logic [dcache_pkg::LINE_W-1:0]    data_mem [dcache_pkg::NUM_LINES];
    logic [dcache_pkg::NUM_LINES-1:0] valid_bits;

    always_ff @(posedge clk) begin
        if (store_we) begin
            tag_mem[store_index]  <= store_tag_w;
            data_mem[store_index] <= store_wline;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_bits <= '0;
        end else if (store_we) begin
            valid_bits[store_index] <= 1'b1;
        end
    end

    // read port returns the new line on a write cycle
    always_ff @(posedge clk) begin
        if (store_we) begin
            store_tag  <= store_tag_w;
            store_line <= store_wline;
        end else begin
            store_tag  <= tag_mem[store_index];
            store_line <= data_mem[store_index];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            store_valid <= 1'b0;
        end else begin
            store_valid <= store_we || valid_bits[store_index];
        end
    end

endmodule

/* hdl/dcache_top.sv */
`timescale 1ns/1ps

module dcache_top (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            rd_req_valid,
    output logic                            rd_req_ready,
    input  logic [dcache_pkg::ADDR_W-1:0]   rd_req_address,
    input  logic                            wr_req_valid,
    output logic                            wr_req_ready,
    input  logic [dcache_pkg::ADDR_W-1:0]   wr_req_address,
    input  logic [dcache_pkg::LINE_W-1:0]   wr_req_data,
    input  logic                            wr_size,
    output logic                            rd_dp_valid,
    input  logic                            rd_dp_ready,
    output logic [dcache_pkg::LINE_W-1:0]   rd_dp_read_data,
    output logic [dcache_pkg::ADDR_W-1:0]   virt_addr,
    input  logic [dcache_pkg::ADDR_W-1:0]   phys_addr,
    input  logic                            tlb_hit,
    input  logic                            tlb_pcd,
    output logic                            page_fault,
    output logic                            wb_cyc,
    output logic                            wb_stb,
    output logic                            wb_we,
    output logic [31:0]                     wb_adr,
    output logic [31:0]                     wb_dat_w,
    output logic [3:0]                      wb_sel,
    input  logic                            wb_ack,
    input  logic [31:0]                     wb_dat_r
);

    logic [dcache_pkg::ADDR_W-1:0]  lookup_addr;
    logic [dcache_pkg::LINE_W-1:0]  write_data;
    logic                           span;
    logic                           is_write;
    logic                           wide_write;
    logic                           req_pending;
    logic                           req_done;
    logic                           next_line;
    logic [dcache_pkg::INDEX_W-1:0] store_index;
    logic                           store_we;
    logic [dcache_pkg::LINE_W-1:0]  store_wline;
    logic [dcache_pkg::TAG_W-1:0]   store_tag_w;
    logic [dcache_pkg::TAG_W-1:0]   store_tag;
    logic                           store_valid;
    logic [dcache_pkg::LINE_W-1:0]  store_line;
    logic                           stage_load;
    logic                           half_sel;
    logic [31:0]                    stage_word;
    logic                           result_valid;
    logic                           result_taken;

    dcache_req_decode u_decode (
        .clk(clk), .reset(reset),
        .rd_req_valid(rd_req_valid), .wr_req_valid(wr_req_valid),
        .rd_req_ready(rd_req_ready), .wr_req_ready(wr_req_ready),
        .rd_req_address(rd_req_address), .wr_req_address(wr_req_address),
        .wr_req_data(wr_req_data), .wr_size(wr_size),
        .req_done(req_done), .next_line(next_line),
        .lookup_addr(lookup_addr), .span(span), .is_write(is_write),
        .wide_write(wide_write), .write_data(write_data), .req_pending(req_pending)
    );

    dcache_ctrl u_ctrl (
        .clk(clk), .reset(reset),
        .req_pending(req_pending), .is_write(is_write), .span(span),
        .wide_write(wide_write), .lookup_addr(lookup_addr), .write_data(write_data),
        .next_line(next_line), .req_done(req_done),
        .virt_addr(virt_addr), .phys_addr(phys_addr), .tlb_hit(tlb_hit),
        .tlb_pcd(tlb_pcd), .page_fault(page_fault),
        .store_index(store_index), .store_we(store_we), .store_wline(store_wline),
        .store_tag_w(store_tag_w), .store_tag(store_tag), .store_valid(store_valid),
        .store_line(store_line),
        .stage_load(stage_load), .half_sel(half_sel), .result_valid(result_valid),
        .result_taken(result_taken), .stage_word(stage_word),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_w(wb_dat_w), .wb_sel(wb_sel), .wb_ack(wb_ack), .wb_dat_r(wb_dat_r)
    );

    dcache_store u_store (
        .clk(clk), .reset(reset),
        .store_index(store_index), .store_we(store_we), .store_wline(store_wline),
        .store_tag_w(store_tag_w), .store_tag(store_tag), .store_valid(store_valid),
        .store_line(store_line)
    );

    dcache_read_align u_align (
        .clk(clk), .reset(reset),
        .stage_load(stage_load), .half_sel(half_sel), .stage_word(stage_word),
        .result_valid(result_valid), .result_taken(result_taken),
        .rd_dp_valid(rd_dp_valid), .rd_dp_ready(rd_dp_ready),
        .rd_dp_read_data(rd_dp_read_data)
    );

endmodule

/* sim/tb_dcache.sv */
`timescale 1ns/1ps

module tb_dcache;

    localparam int NUM_OPS = 400;
    localparam int WAIT_LIMIT = 300;
    localparam logic [31:0] PHYS_OFFSET = 32'h0001_0000;

    logic        clk;
    logic        reset;
    logic        rd_req_valid;
    logic        rd_req_ready;
    logic [31:0] rd_req_address;
    logic        wr_req_valid;
    logic        wr_req_ready;
    logic [31:0] wr_req_address;
    logic [63:0] wr_req_data;
    logic        wr_size;
    logic        rd_dp_valid;
    logic        rd_dp_ready;
    logic [63:0] rd_dp_read_data;
    logic [31:0] virt_addr;
    logic [31:0] phys_addr;
    logic        tlb_hit;
    logic        tlb_pcd;
    logic        page_fault;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [31:0] wb_adr;
    logic [31:0] wb_dat_w;
    logic [3:0]  wb_sel;
    logic        wb_ack;
    logic [31:0] wb_dat_r;
    logic        ack_stall;
    logic [31:0] rd_count;
    logic [31:0] wr_count;

    logic [15:0] lfsr_state;
    // flat word memory indexed by virtual address bits 13:2
    logic [31:0] model [4096];
    // addresses of acknowledged bus transfers in the current operation
    logic [31:0] bus_log [$];

    dcache_top i_dut (
        .clk(clk), .reset(reset),
        .rd_req_valid(rd_req_valid), .rd_req_ready(rd_req_ready),
        .rd_req_address(rd_req_address),
        .wr_req_valid(wr_req_valid), .wr_req_ready(wr_req_ready),
        .wr_req_address(wr_req_address), .wr_req_data(wr_req_data), .wr_size(wr_size),
        .rd_dp_valid(rd_dp_valid), .rd_dp_ready(rd_dp_ready),
        .rd_dp_read_data(rd_dp_read_data),
        .virt_addr(virt_addr), .phys_addr(phys_addr), .tlb_hit(tlb_hit),
        .tlb_pcd(tlb_pcd), .page_fault(page_fault),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_w(wb_dat_w), .wb_sel(wb_sel), .wb_ack(wb_ack), .wb_dat_r(wb_dat_r)
    );

    tb_dcache_env u_env (
        .clk(clk), .reset(reset), .ack_stall(ack_stall),
        .virt_addr(virt_addr), .phys_addr(phys_addr), .tlb_hit(tlb_hit),
        .tlb_pcd(tlb_pcd),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_w(wb_dat_w), .wb_sel(wb_sel), .wb_ack(wb_ack), .wb_dat_r(wb_dat_r),
        .rd_count(rd_count), .wr_count(wr_count)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic bit lfsr_bit();
        bit out;
        out = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out) begin
            lfsr_state = lfsr_state ^ 16'hb400;
        end
        return out;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        int          i;
        v = 32'd0;
        for (i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_bit()};
        end
        return v;
    endfunction

    task automatic stop_run(input string what);
        $display("%s", what);
        $display("TB FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_read(input string name, input dcache_pkg::dcache_line_u exp,
                              input dcache_pkg::dcache_line_u act);
        if (act.raw !== exp.raw) begin
            stop_run($sformatf("Fail %s expected %h actual %h", name, exp.raw, act.raw));
        end
    endtask

    task automatic check_fault(input string name, input bit exp, input bit act);
        if (act !== exp) begin
            stop_run($sformatf("Fail %s page_fault expected %b actual %b", name, exp, act));
        end
    endtask

    task automatic check_count(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        if (act !== exp) begin
            stop_run($sformatf("Fail %s bus cycles expected %0d actual %0d", name, exp, act));
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
        if (act !== exp) begin
            stop_run($sformatf("Fail %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic report_timeout(input string what);
        dcache_pkg::ctrl_state_e st;
        st = i_dut.u_ctrl.state;
        stop_run($sformatf("timeout waiting for %s, ctrl state %s", what, st.name()));
    endtask

    // one cycle, bus watched and ack stall picked fresh each time
    task automatic step_cycle();
        @(negedge clk);
        if (wb_stb !== wb_cyc) stop_run("wb_stb does not follow wb_cyc");
        if (wb_cyc && wb_ack) begin
            if (wb_adr[31:14] != PHYS_OFFSET[31:14]) begin
                stop_run($sformatf("Wishbone address %h outside the physical window", wb_adr));
            end
            bus_log.push_back(wb_adr);
        end
        ack_stall = lfsr_bit();
    endtask

    task automatic do_read(input logic [31:0] addr, input string name, input logic [1:0] pg);
        dcache_pkg::dcache_line_u exp_line;
        dcache_pkg::dcache_line_u held;
        logic [31:0] rd0;
        logic [31:0] wr0;
        logic [11:0] idx;
        int          cnt;
        bit          fault_seen;
        bit          done;
        bit          hold;
        rd0 = rd_count;
        wr0 = wr_count;
        idx = addr[13:2];
        fault_seen = 1'b0;
        done = 1'b0;
        hold = 1'b0;
        bus_log.delete();
        rd_req_address = addr;
        rd_req_valid = 1'b1;
        cnt = 0;
        while (!rd_req_ready) begin
            step_cycle();
            cnt++;
            if (cnt > WAIT_LIMIT) report_timeout("rd_req_ready");
        end
        step_cycle();
        rd_req_valid = 1'b0;
        cnt = 0;
        while (!done) begin
            if (page_fault) begin
                fault_seen = 1'b1;
                done = 1'b1;
            end else if (rd_dp_valid) begin
                if (pg == 2'd2) stop_run("rd_dp_valid raised for a faulting read");
                // data must not move while the result is held
                if (hold) check_read({name, " held"}, held, rd_dp_read_data);
                held = rd_dp_read_data;
                rd_dp_ready = lfsr_bit();
                hold = !rd_dp_ready;
                done = rd_dp_ready;
            end
            if (!done) begin
                step_cycle();
                cnt++;
                if (cnt > WAIT_LIMIT) report_timeout("rd_dp_valid or page_fault");
            end
        end
        step_cycle();
        rd_dp_ready = 1'b0;
        check_fault(name, pg == 2'd2, fault_seen);
        if (pg == 2'd2) begin
            check_count(name, 32'd0, rd_count - rd0);
        end else begin
            exp_line.word[0] = model[idx];
            exp_line.word[1] = model[idx + 12'd1];
            check_read(name, exp_line, held);
            if (pg == 2'd1) begin
                check_count(name, 32'd2, rd_count - rd0);
                check_word({name, " wb_adr 0"}, addr + PHYS_OFFSET, bus_log[0]);
                check_word({name, " wb_adr 1"}, addr + PHYS_OFFSET + 32'd4, bus_log[1]);
            end
        end
        check_count(name, 32'd0, wr_count - wr0);
    endtask

    task automatic do_write(input logic [31:0] addr, input logic [63:0] data, input logic wide,
                            input string name, input logic [1:0] pg);
        logic [31:0] rd0;
        logic [31:0] wr0;
        logic [11:0] idx;
        int          cnt;
        bit          fault_seen;
        rd0 = rd_count;
        wr0 = wr_count;
        idx = addr[13:2];
        fault_seen = 1'b0;
        bus_log.delete();
        wr_req_address = addr;
        wr_req_data = data;
        wr_size = wide;
        wr_req_valid = 1'b1;
        cnt = 0;
        while (!wr_req_ready) begin
            step_cycle();
            cnt++;
            if (cnt > WAIT_LIMIT) report_timeout("wr_req_ready before accept");
        end
        step_cycle();
        wr_req_valid = 1'b0;
        cnt = 0;
        while (!wr_req_ready) begin
            if (page_fault) fault_seen = 1'b1;
            if (rd_dp_valid) stop_run("rd_dp_valid raised during a write");
            step_cycle();
            cnt++;
            if (cnt > WAIT_LIMIT) report_timeout("wr_req_ready after write");
        end
        check_fault(name, pg == 2'd2, fault_seen);
        check_count(name, 32'd0, rd_count - rd0);
        if (pg == 2'd2) begin
            check_count(name, 32'd0, wr_count - wr0);
        end else begin
            check_count(name, wide ? 32'd2 : 32'd1, wr_count - wr0);
            check_word({name, " wb_adr 0"}, addr + PHYS_OFFSET, bus_log[0]);
            model[idx] = data[31:0];
            check_word({name, " mem 0"}, model[idx], u_env.mem[idx]);
            if (wide) begin
                check_word({name, " wb_adr 1"}, addr + PHYS_OFFSET + 32'd4, bus_log[1]);
                model[idx + 12'd1] = data[63:32];
                check_word({name, " mem 1"}, model[idx + 12'd1], u_env.mem[idx + 12'd1]);
            end
        end
    endtask

    initial begin
        logic [31:0] r;
        logic [31:0] addr;
        logic [63:0] data;
        logic [1:0]  pg;
        logic        is_wr;
        logic        wide;
        string       name;
        lfsr_state = 16'd24505;
        reset = 1'b1;
        rd_req_valid = 1'b0;
        rd_req_address = 32'd0;
        wr_req_valid = 1'b0;
        wr_req_address = 32'd0;
        wr_req_data = 64'd0;
        wr_size = 1'b0;
        rd_dp_ready = 1'b0;
        ack_stall = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        for (int i = 0; i < 4096; i++) begin
            model[i] = u_env.mem[i];
        end
        for (int n = 0; n < NUM_OPS; n++) begin
            r = rand_bits(2);
            is_wr = (r[1:0] == 2'd0);
            r = rand_bits(2);
            // cacheable page gets half of the traffic
            pg = (r[1:0] == 2'd3) ? 2'd0 : r[1:0];
            r = rand_bits(8);
            addr = {18'd0, pg, 2'b00, r[7:0], 2'b00};
            if (is_wr) begin
                data[63:32] = rand_bits(32);
                data[31:0] = rand_bits(32);
                r = rand_bits(1);
                wide = r[0];
                name = $sformatf("op%0d write %h size %0d", n, addr, wide ? 8 : 4);
                do_write(addr, data, wide, name, pg);
            end else begin
                name = $sformatf("op%0d read %h", n, addr);
                do_read(addr, name, pg);
                if (pg == 2'd1) do_read(addr, {name, " repeat"}, pg);
            end
        end
        $display("TB PASSED");
        $finish;
    end

endmodule

/* sim/tb_dcache_env.sv */
`timescale 1ns/1ps

module tb_dcache_env (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            ack_stall,
    input  logic [dcache_pkg::ADDR_W-1:0]   virt_addr,
    output logic [dcache_pkg::ADDR_W-1:0]   phys_addr,
    output logic                            tlb_hit,
    output logic                            tlb_pcd,
    input  logic                            wb_cyc,
    input  logic                            wb_stb,
    input  logic                            wb_we,
    input  logic [31:0]                     wb_adr,
    input  logic [31:0]                     wb_dat_w,
    input  logic [3:0]                      wb_sel,
    output logic                            wb_ack,
    output logic [31:0]                     wb_dat_r,
    output logic [31:0]                     rd_count,
    output logic [31:0]                     wr_count
);

    // physical window 0x10000 to 0x13fff, one word per entry
    logic [31:0] mem [4096];
    logic [11:0] word_idx;

    initial begin
        for (int i = 0; i < 4096; i++) begin
            mem[i] = (i * 32'h9e37_79b1) ^ 32'h5a5a_0f0f;
        end
    end

    // page 0 cacheable, page 1 uncacheable, everything else faults
    assign phys_addr = virt_addr + 32'h0001_0000;
    assign tlb_hit   = (virt_addr[31:14] == 18'd0) && (virt_addr[13:12] < 2'd2);
    assign tlb_pcd   = (virt_addr[13:12] == 2'd1);

    assign word_idx = wb_adr[13:2];

    always @(posedge clk) begin
        if (reset) begin
            wb_ack   <= 1'b0;
            wb_dat_r <= 32'd0;
            rd_count <= 32'd0;
            wr_count <= 32'd0;
        end else if (wb_cyc && wb_stb && !wb_ack && !ack_stall) begin
            wb_ack <= 1'b1;
            if (wb_we) begin
                if (wb_sel == 4'hf) begin
                    mem[word_idx] <= wb_dat_w;
                end
                wr_count <= wr_count + 32'd1;
            end else begin
                wb_dat_r <= mem[word_idx];
                rd_count <= rd_count + 32'd1;
            end
        end else begin
            wb_ack <= 1'b0;
        end
    end

endmodule

/* sources.f */
common/dcache_pkg.sv
dcache/dcache_req_decode.sv
dcache/dcache_ctrl.sv
dcache/dcache_store.sv
dcache/dcache_read_align.sv
hdl/dcache_top.sv
sim/tb_dcache_env.sv
sim/tb_dcache.sv
